/* cam_emu.f */
hdl/cam_emu_pkg.sv
hdl/cam_interval_timer.sv
hdl/cam_frame_fsm.sv
hdl/cam_pixel_source.sv
hdl/cam_emu_top.sv
testbench/cam_emu_tb.sv

/* hdl/cam_emu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and frame constants for the camera emulator.
// cnt_t must hold 17 line times at the chosen HRES and TP.
// blanking lengths are in line times.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cam_emu_pkg;

    typedef logic [15:0] cnt_t;      // timer target and count.
    typedef logic [15:0] coord_t;    // column or line index.
    typedef logic [23:0] pixel_t;    // rgb888, red on top.
    typedef logic [7:0]  cam_byte_t; // one byte on the data bus.

    // position of the byte currently on the bus.
    typedef struct packed {
        coord_t col;
        coord_t line;
        logic   byte_sel;  // 0 is the first byte of a pixel.
        logic   frame_sel; // 0 is frame 0.
    } cam_ptr_t;

    typedef enum logic [2:0] {
        ST_RST,
        ST_SOF,
        ST_WAIT_SOF,
        ST_SEND_LINE,
        ST_WAIT_EOF
    } cam_state_e;

    // vertical blanking, in line times.
    localparam int VSYNC_LINES = 3;
    localparam int PRE_LINES   = 17;
    localparam int POST_LINES  = 10;

    // blank pixels added to HRES in one line time.
    localparam int HBLANK_PIX  = 144;

endpackage

/* hdl/cam_emu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OV7670-style parallel camera emulator, top level.
// the pixel clock comes from outside and is forwarded as is.
// no back-pressure: data streams whenever en_i is high.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cam_emu_top
    import cam_emu_pkg::*;
#(
    parameter int HRES = 640,
    parameter int VRES = 480,
    parameter int TP   = 2
) (
    input  logic      cam_pclk_o,
    input  logic      s_rstn,
    input  logic      en_i,
    output logic      cam_clk_o,
    output logic      cam_vsync_o,
    output logic      cam_href_o,
    output cam_byte_t cam_data_o
);

    logic     s_timer_start;
    cnt_t     s_timer_target;
    logic     s_timer_done;
    cam_ptr_t s_ptr;

    assign cam_clk_o = cam_pclk_o; // forwarded pixel clock.

    cam_interval_timer timer_i (
        .cam_pclk_o (cam_pclk_o),
        .s_rstn     (s_rstn),
        .en_i       (en_i),
        .start_i    (s_timer_start),
        .target_i   (s_timer_target),
        .done_o     (s_timer_done)
    );

    cam_frame_fsm #(
        .HRES (HRES),
        .VRES (VRES),
        .TP   (TP)
    ) fsm_i (
        .cam_pclk_o     (cam_pclk_o),
        .s_rstn         (s_rstn),
        .en_i           (en_i),
        .timer_done_i   (s_timer_done),
        .timer_start_o  (s_timer_start),
        .timer_target_o (s_timer_target),
        .ptr_o          (s_ptr),
        .vsync_o        (cam_vsync_o),
        .href_o         (cam_href_o)
    );

    cam_pixel_source pixel_i (
        .ptr_i  (s_ptr),
        .data_o (cam_data_o)
    );

endmodule

/* hdl/cam_frame_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame sequencer: vsync, blanking, VRES lines of HRES pixels.
// href stays high for the whole active frame, no line gaps.
// en_i low restarts at frame 0 on the next enabled cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cam_frame_fsm
    import cam_emu_pkg::*;
#(
    parameter int HRES = 640,
    parameter int VRES = 480,
    parameter int TP   = 2
) (
    input  logic     cam_pclk_o,
    input  logic     s_rstn,
    input  logic     en_i,
    input  logic     timer_done_i,
    output logic     timer_start_o,
    output cnt_t     timer_target_o,
    output cam_ptr_t ptr_o,
    output logic     vsync_o,
    output logic     href_o
);

    localparam int TLINE = (HRES + HBLANK_PIX) * TP; // cycles per line time.

    localparam cnt_t SOF_CNT  = cnt_t'(VSYNC_LINES * TLINE);
    localparam cnt_t PRE_CNT  = cnt_t'(PRE_LINES * TLINE);
    localparam cnt_t POST_CNT = cnt_t'(POST_LINES * TLINE);

    localparam coord_t LAST_COL  = coord_t'(HRES - 1);
    localparam coord_t LAST_LINE = coord_t'(VRES - 1);

    cam_state_e r_state;
    cam_state_e s_state;
    cam_ptr_t   r_ptr;
    cam_ptr_t   s_ptr;
    logic       s_start;
    cnt_t       s_target;

    always_comb begin
        s_state  = r_state;
        s_ptr    = r_ptr;
        s_start  = 1'b0;
        s_target = '0;
        case (r_state)
            ST_RST: begin
                s_state         = ST_SOF;
                s_start         = 1'b1;
                s_target        = SOF_CNT;
                s_ptr.byte_sel  = 1'b0;
                s_ptr.frame_sel = 1'b0;
            end
            ST_SOF: begin
                if (timer_done_i) begin
                    s_state  = ST_WAIT_SOF;
                    s_start  = 1'b1;
                    s_target = PRE_CNT;
                end
            end
            ST_WAIT_SOF: begin
                if (timer_done_i) begin
                    s_state        = ST_SEND_LINE;
                    s_ptr.col      = '0;
                    s_ptr.line     = '0;
                    s_ptr.byte_sel = 1'b0;
                end
            end
            ST_SEND_LINE: begin
                s_ptr.byte_sel = ~r_ptr.byte_sel;
                if (r_ptr.byte_sel) begin // second byte of the pixel.
                    if (r_ptr.col == LAST_COL) begin
                        s_ptr.col = '0;
                        if (r_ptr.line == LAST_LINE) begin
                            s_state    = ST_WAIT_EOF; // last byte of the frame.
                            s_start    = 1'b1;
                            s_target   = POST_CNT;
                            s_ptr.line = '0;
                        end else begin
                            s_ptr.line = r_ptr.line + coord_t'(1);
                        end
                    end else begin
                        s_ptr.col = r_ptr.col + coord_t'(1);
                    end
                end
            end
            ST_WAIT_EOF: begin
                if (timer_done_i) begin
                    s_state         = ST_SOF;
                    s_start         = 1'b1;
                    s_target        = SOF_CNT;
                    s_ptr.frame_sel = ~r_ptr.frame_sel; // alternate the images.
                end
            end
            default: begin
                s_state = ST_RST;
            end
        endcase
    end

    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            r_state <= ST_RST;
            r_ptr   <= '0;
        end else if (!en_i) begin
            r_state <= ST_RST;
            r_ptr   <= '0;
        end else begin
            r_state <= s_state;
            r_ptr   <= s_ptr;
        end
    end

    // sync lines drop with en_i, even before the state follows.
    assign vsync_o = en_i & (r_state == ST_SOF);
    assign href_o  = en_i & (r_state == ST_SEND_LINE);

    assign timer_start_o  = s_start;
    assign timer_target_o = s_target;
    assign ptr_o          = r_ptr;

endmodule

/* hdl/cam_interval_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one-shot interval timer. a start is taken only while idle.
// done pulses for one cycle, N+2 cycles after a start with N.
// en_i low cancels a running interval.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cam_interval_timer
    import cam_emu_pkg::*;
(
    input  logic cam_pclk_o,
    input  logic s_rstn,
    input  logic en_i,
    input  logic start_i,
    input  cnt_t target_i,
    output logic done_o
);

    cnt_t r_counter;
    cnt_t r_target;
    logic r_active;
    logic r_done;

    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            r_counter <= '0;
            r_active  <= 1'b0;
            r_done    <= 1'b0;
        end else if (!en_i) begin
            r_counter <= '0;
            r_active  <= 1'b0;
            r_done    <= 1'b0;
        end else if (r_active) begin
            if (r_counter == r_target) begin
                r_done    <= 1'b1; // single pulse, back to idle.
                r_active  <= 1'b0;
                r_counter <= '0;
            end else begin
                r_counter <= r_counter + 1'b1;
                r_done    <= 1'b0;
            end
        end else begin
            r_counter <= '0;
            r_done    <= 1'b0;
            if (start_i) begin
                r_active <= 1'b1;
            end
        end
    end

    always_ff @(posedge cam_pclk_o) begin
        if (start_i && !r_active) begin
            r_target <= target_i; // taken with the accepted start.
        end
    end

    assign done_o = r_done;

endmodule

/* hdl/cam_pixel_source.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// computed test pattern in place of stored images.
// frame 1 is the bitwise inverse of frame 0.
// output is rgb565, red first, purely combinational.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cam_pixel_source
    import cam_emu_pkg::*;
(
    input  cam_ptr_t  ptr_i,
    output cam_byte_t data_o
);

    logic [7:0] s_red;
    logic [7:0] s_green;
    logic [7:0] s_blue;
    pixel_t     s_pattern;
    pixel_t     s_pixel;
    cam_byte_t  s_first;
    cam_byte_t  s_second;

    // frame 0 pattern, all arithmetic wraps at 8 bits.
    assign s_red   = ptr_i.col[7:0];
    assign s_green = {ptr_i.line[3:0], 4'h0};      // line times 16.
    assign s_blue  = ptr_i.col[7:0] + ptr_i.line[7:0];

    assign s_pattern = {s_red, s_green, s_blue};
    assign s_pixel   = ptr_i.frame_sel ? ~s_pattern : s_pattern;

    // rgb565 split: r[7:3] g[7:5], then g[4:2] b[7:3].
    assign s_first  = {s_pixel[23:19], s_pixel[15:13]};
    assign s_second = {s_pixel[12:10], s_pixel[7:3]};

    assign data_o = ptr_i.byte_sel ? s_second : s_first;

endmodule

/* testbench/cam_emu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the camera emulator at HRES 16, VRES 4, TP 2.
// outputs are sampled on the falling edge, just before en_i moves.
// stops at the first mismatch or timeout.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cam_emu_tb;

    localparam int HRES  = 16;
    localparam int VRES  = 4;
    localparam int TP    = 2;
    localparam int TLINE = (HRES + 144) * TP; // cycles per line time.

    localparam int VSYNC_CYC = 3 * TLINE + 2;
    localparam int PRE_CYC   = 17 * TLINE + 2;
    localparam int ACT_CYC   = 2 * HRES * VRES;
    localparam int POST_CYC  = 10 * TLINE + 2;
    localparam int FRAME_CYC = VSYNC_CYC + PRE_CYC + ACT_CYC + POST_CYC;

    localparam int WAIT_LIMIT = FRAME_CYC;

    // model phases.
    localparam int PH_IDLE   = 0;
    localparam int PH_VSYNC  = 1;
    localparam int PH_PRE    = 2;
    localparam int PH_ACTIVE = 3;
    localparam int PH_POST   = 4;

    logic       cam_pclk_o;
    logic       s_rstn;
    logic       en_i;
    logic       cam_clk_o;
    logic       cam_vsync_o;
    logic       cam_href_o;
    logic [7:0] cam_data_o;

    integer seed;
    string  cur_test;

    bit en_req;
    bit rstn_req;
    bit en_cur;   // level applied over the last rising edge.
    bit rstn_cur;
    bit samp_vsync;
    bit samp_href;

    int m_phase;
    int m_left;   // cycles left in the current phase.
    bit m_frame;

    cam_emu_top #(
        .HRES (HRES),
        .VRES (VRES),
        .TP   (TP)
    ) dut_i (
        .cam_pclk_o  (cam_pclk_o),
        .s_rstn      (s_rstn),
        .en_i        (en_i),
        .cam_clk_o   (cam_clk_o),
        .cam_vsync_o (cam_vsync_o),
        .cam_href_o  (cam_href_o),
        .cam_data_o  (cam_data_o)
    );

    always #50 cam_pclk_o = ~cam_pclk_o;

    task automatic stop_failing();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
            stop_failing();
        end
    endtask

    // rgb565 byte of the test pattern with frame 1 inverted.
    function automatic logic [7:0] pattern_byte(input int col, input int line,
                                                 input bit frame, input bit second);
        logic [7:0]  r;
        logic [7:0]  g;
        logic [7:0]  b;
        logic [15:0] rgb565;
        r = col[7:0];
        g = 8'((line * 16) % 256);
        b = 8'((col + line) % 256);
        if (frame) begin
            r = ~r;
            g = ~g;
            b = ~b;
        end
        rgb565 = {r[7:3], g[7:2], b[7:3]};
        return second ? rgb565[7:0] : rgb565[15:8];
    endfunction

    // one rising edge of the reference waveform.
    task automatic model_step(input bit run);
        if (!run) begin
            m_phase = PH_IDLE;
            m_frame = 1'b0;
        end else if (m_phase == PH_IDLE) begin
            m_phase = PH_VSYNC;
            m_left  = VSYNC_CYC;
        end else begin
            m_left = m_left - 1;
            if (m_left == 0) begin
                case (m_phase)
                    PH_VSYNC: begin
                        m_phase = PH_PRE;
                        m_left  = PRE_CYC;
                    end
                    PH_PRE: begin
                        m_phase = PH_ACTIVE;
                        m_left  = ACT_CYC;
                    end
                    PH_ACTIVE: begin
                        m_phase = PH_POST;
                        m_left  = POST_CYC;
                    end
                    default: begin
                        m_phase = PH_VSYNC; // next frame with the other image.
                        m_left  = VSYNC_CYC;
                        m_frame = ~m_frame;
                    end
                endcase
            end
        end
    endtask

    // one clock. sample, compare with the model, then drive inputs.
    task automatic run_cycle();
        bit exp_vsync;
        bit exp_href;
        int idx;
        @(negedge cam_pclk_o);
        model_step(en_cur && rstn_cur);
        exp_vsync  = en_cur && (m_phase == PH_VSYNC);
        exp_href   = en_cur && (m_phase == PH_ACTIVE);
        samp_vsync = cam_vsync_o;
        samp_href  = cam_href_o;
        check_value(cur_test, "vsync level", exp_vsync, cam_vsync_o);
        check_value(cur_test, "href level", exp_href, cam_href_o);
        if (exp_href) begin
            idx = ACT_CYC - m_left; // byte index within the frame.
            check_value(cur_test, "pixel byte",
                        pattern_byte((idx / 2) % HRES, (idx / 2) / HRES, m_frame, idx % 2),
                        cam_data_o);
        end
        en_i     <= en_req;
        s_rstn   <= rstn_req;
        en_cur   = en_req;
        rstn_cur = rstn_req;
    endtask

    // counts cycles until vsync or href reaches the level.
    task automatic wait_level(input bit on_href, input bit level, input string what,
                              output int cycles);
        cycles = 0;
        do begin
            run_cycle();
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
                stop_failing();
            end
        end while ((on_href ? samp_href : samp_vsync) != level);
    endtask

    task automatic check_frame(input string name, input int gap);
        int n;
        cur_test = name;
        wait_level(1'b0, 1'b1, "vsync rising", n);
        check_value(name, "cycles to vsync", gap, n);
        wait_level(1'b0, 1'b0, "vsync falling", n);
        check_value(name, "vsync width", VSYNC_CYC, n);
        wait_level(1'b1, 1'b1, "href rising", n);
        check_value(name, "vsync to href", PRE_CYC, n);
        wait_level(1'b1, 1'b0, "href falling", n);
        check_value(name, "href width", ACT_CYC, n);
    endtask

    // forwarded clock is checked shortly after both edges.
    always @(posedge cam_pclk_o or negedge cam_pclk_o) begin
        #10;
        check_value("clock forwarding", "cam_clk_o", cam_pclk_o, cam_clk_o);
    end

    initial begin
        int run_len;
        int off_len;
        cam_pclk_o = 1'b0;
        s_rstn     = 1'b0;
        en_i       = 1'b1;
        seed       = 32'hfe36;
        en_req     = 1'b1;
        rstn_req   = 1'b0;
        en_cur     = 1'b1;
        rstn_cur   = 1'b0;
        m_phase    = PH_IDLE;
        m_left     = 0;
        m_frame    = 1'b0;
        cur_test   = "reset";

        repeat (7) run_cycle();
        rstn_req = 1'b1;
        run_cycle(); // released after the 8th cycle.

        check_frame("frame 0 pattern", 1);
        check_frame("frame 1 inverted", POST_CYC);
        check_frame("frame 2 pattern", POST_CYC);

        for (int r = 0; r < 4; r++) begin
            run_len  = $unsigned($random(seed)) % FRAME_CYC;
            off_len  = 1 + $unsigned($random(seed)) % 40;
            cur_test = "random restart";
            repeat (run_len) run_cycle();
            en_req = 1'b0;
            repeat (off_len) run_cycle(); // en_i low for off_len cycles.
            en_req = 1'b1;
            // en_i rises in the first wait cycle, vsync follows one cycle later.
            check_frame("restart frame 0", 2);
            check_frame("restart frame 1", POST_CYC);
        end

        $display("All tests passed");
        $finish;
    end

endmodule
